// File: Bender.yml
package:
  name: st_mem_glue

sources:
  - source/st_mem_pkg.sv
  - source/ram_window.sv
  - source/upload_addr.sv
  - source/viking_detect.sv
  - source/sdram_port_mux.sv
  - source/st_mem_glue.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/tb_st_mem_glue.sv

// File: sim.f
+incdir+verif
source/st_mem_pkg.sv
source/ram_window.sv
source/upload_addr.sv
source/viking_detect.sv
source/sdram_port_mux.sv
source/st_mem_glue.sv
verif/tb_st_mem_glue.sv

// File: source/ram_window.sv
`timescale 1ns/100ps

module ram_window (
	input  st_mem_pkg::st_cfg_t           cfg_i,
	input  logic                          viking_enable_i,
	input  logic [st_mem_pkg::addr_w-1:0] addr_i,
	output logic                          ram_en_o
);

	// installed st ram below the size limit
	logic in_ram;
	// viking frame buffer window
	logic in_viking;
	// window top for the current mode
	logic [5:0] viking_top;

	// word address bit n is byte address bit n+1
	always_comb begin
		case (cfg_i.mem_size)
			st_mem_pkg::mem_512k: in_ram = (addr_i[22:18] == '0);
			st_mem_pkg::mem_1m:   in_ram = (addr_i[22:19] == '0);
			st_mem_pkg::mem_2m:   in_ram = (addr_i[22:20] == '0);
			st_mem_pkg::mem_4m:   in_ram = (addr_i[22:21] == '0);
			st_mem_pkg::mem_8m:   in_ram = ~addr_i[22];
			// everything up to dfffff
			// e00000 and up stays rom and io
			st_mem_pkg::mem_14m:  in_ram = ~&addr_i[22:20];
			default:              in_ram = 1'b0;
		endcase
	end

	// steroids moves the card up to e8
	assign viking_top = cfg_i.steroids ? st_mem_pkg::viking_win_hi :
	                                     st_mem_pkg::viking_win_lo;

	assign in_viking = viking_enable_i && (addr_i[22:17] == viking_top);

	assign ram_en_o = in_ram | in_viking;

endmodule

// File: source/sdram_port_mux.sv
`timescale 1ns/100ps

module sdram_port_mux (
	input  logic                          clk_32,
	input  logic                          xsint,
	input  st_mem_pkg::st_cfg_t           cfg_i,
	input  st_mem_pkg::chip_ram_t         chip_i,
	input  logic                          mhz8_en1_i,
	input  logic [1:0]                    bus_cycle_i,
	input  logic                          viking_enable_i,
	input  logic                          viking_active_i,
	input  logic [st_mem_pkg::addr_w-1:0] viking_vaddr_i,
	input  logic                          viking_read_i,
	input  logic                          up_active_i,
	input  logic [st_mem_pkg::addr_w-1:0] up_addr_i,
	input  logic [st_mem_pkg::data_w-1:0] up_data_i,
	input  logic                          up_toggle_i,
	input  logic                          tos192k_i,
	input  logic [st_mem_pkg::addr_w-1:0] mbus_a_i,
	input  logic                          rom2_n_i,
	output st_mem_pkg::sdram_req_t        sdram_o,
	output logic [st_mem_pkg::addr_w-1:0] rom_addr_o
);

	logic cpu_pre;
	logic cpu_cycle;
	logic viking_cycle;
	logic ras_n_d;
	// copy of the upload toggle
	logic toggle_d;
	// one clock upload write
	logic data_wr;
	logic ram_en;
	logic chip_req;
	logic up_sel;
	logic vk_sel;

	////////////////////////////////////////
	// slot decode
	////////////////////////////////////////

	// turbo bus gives the cpu the shifter slot too
	assign cpu_pre      = (bus_cycle_i == st_mem_pkg::slot_cpu_pre);
	assign cpu_cycle    = (bus_cycle_i == st_mem_pkg::slot_cpu) ||
	                      (cfg_i.turbo_bus && bus_cycle_i == st_mem_pkg::slot_video);
	// video fetch, moves one slot later in turbo
	assign viking_cycle = (!cfg_i.turbo_bus && bus_cycle_i == st_mem_pkg::slot_video) ||
	                      (cfg_i.turbo_bus && bus_cycle_i == st_mem_pkg::slot_extra);

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			ras_n_d  <= 1'b1;
			toggle_d <= 1'b0;
			data_wr  <= 1'b0;
		end else begin
			ras_n_d <= chip_i.ras_n;
			data_wr <= 1'b0;
			// sample the toggle just before a cpu slot
			if (cpu_pre && mhz8_en1_i) begin
				toggle_d <= up_toggle_i;
				if (up_toggle_i ^ toggle_d)
					data_wr <= 1'b1;
			end
		end
	end

	ram_window ram_window_i (
		.cfg_i           (cfg_i),
		.viking_enable_i (viking_enable_i),
		.addr_i          (chip_i.addr),
		.ram_en_o        (ram_en)
	);

	// ras falling edge, address zero is refresh
	assign chip_req = ras_n_d & ~chip_i.ras_n & (|chip_i.addr) & ram_en;

	assign up_sel = cpu_cycle & up_active_i;
	assign vk_sel = viking_cycle & viking_active_i & viking_read_i;

	////////////////////////////////////////
	// source select
	////////////////////////////////////////

	always_comb begin
		sdram_o.din = up_active_i ? up_data_i : chip_i.din;
		if (up_sel) begin
			sdram_o.addr = up_addr_i;
			sdram_o.req  = data_wr;
			sdram_o.we   = 1'b1;
			sdram_o.uds  = 1'b1;
			sdram_o.lds  = 1'b1;
		end else if (vk_sel) begin
			// full word read for the card
			sdram_o.addr = viking_vaddr_i;
			sdram_o.req  = 1'b1;
			sdram_o.we   = 1'b0;
			sdram_o.uds  = 1'b1;
			sdram_o.lds  = 1'b1;
		end else begin
			sdram_o.addr = chip_i.addr;
			sdram_o.req  = chip_req;
			sdram_o.we   = ~chip_i.we_n;
			sdram_o.uds  = chip_i.uds;
			sdram_o.lds  = chip_i.lds;
		end
	end

	// rom2 lands on e00000, or fc0000 for a 192k tos
	always_comb begin
		if (rom2_n_i)
			rom_addr_o = mbus_a_i;
		else if (tos192k_i)
			rom_addr_o = {4'hf, 2'b11, mbus_a_i[16:0]};
		else
			rom_addr_o = {4'he, 2'b00, mbus_a_i[16:0]};
	end

	// bus cycle must have advanced into a cpu slot by the write
	a_upload_in_cpu_slot: assert property (
		@(posedge clk_32) disable iff (!xsint)
		data_wr |-> cpu_cycle
	);

endmodule

// File: source/st_mem_glue.sv
`timescale 1ns/100ps

module st_mem_glue (
	input  logic                          clk_32,
	input  logic                          xsint,
	input  st_mem_pkg::st_cfg_t           cfg_i,
	input  st_mem_pkg::ioctl_t            ioctl_i,
	input  st_mem_pkg::chip_ram_t         chip_i,
	input  logic [st_mem_pkg::addr_w-1:0] mbus_a_i,
	input  logic                          as_n_i,
	input  logic                          rom2_n_i,
	input  logic [1:0]                    bus_cycle_i,
	input  logic                          mhz8_en1_i,
	input  logic [st_mem_pkg::addr_w-1:0] viking_vaddr_i,
	input  logic                          viking_read_i,
	output st_mem_pkg::sdram_req_t        sdram_o,
	output logic [st_mem_pkg::addr_w-1:0] rom_addr_o,
	output logic                          viking_active_o,
	output logic                          tos192k_o
);

	// upload state
	logic                          up_active;
	logic [st_mem_pkg::addr_w-1:0] up_addr;
	logic [st_mem_pkg::data_w-1:0] up_data;
	logic                          up_toggle;
	// card option usable with this memory size
	logic                          viking_enable;

	////////////////////////////////////////
	// rom and cartridge upload
	////////////////////////////////////////

	upload_addr upload_addr_i (
		.clk_32      (clk_32),
		.xsint       (xsint),
		.ioctl_i     (ioctl_i),
		.up_active_o (up_active),
		.up_addr_o   (up_addr),
		.up_data_o   (up_data),
		.up_toggle_o (up_toggle),
		.tos192k_o   (tos192k_o)
	);

	viking_detect viking_detect_i (
		.clk_32          (clk_32),
		.xsint           (xsint),
		.cfg_i           (cfg_i),
		.mbus_a_i        (mbus_a_i),
		.as_n_i          (as_n_i),
		.mhz8_en1_i      (mhz8_en1_i),
		.viking_enable_o (viking_enable),
		.viking_active_o (viking_active_o)
	);

	////////////////////////////////////////
	// sdram port
	////////////////////////////////////////

	sdram_port_mux sdram_port_mux_i (
		.clk_32          (clk_32),
		.xsint           (xsint),
		.cfg_i           (cfg_i),
		.chip_i          (chip_i),
		.mhz8_en1_i      (mhz8_en1_i),
		.bus_cycle_i     (bus_cycle_i),
		.viking_enable_i (viking_enable),
		.viking_active_i (viking_active_o),
		.viking_vaddr_i  (viking_vaddr_i),
		.viking_read_i   (viking_read_i),
		.up_active_i     (up_active),
		.up_addr_i       (up_addr),
		.up_data_i       (up_data),
		.up_toggle_i     (up_toggle),
		.tos192k_i       (tos192k_o),
		.mbus_a_i        (mbus_a_i),
		.rom2_n_i        (rom2_n_i),
		.sdram_o         (sdram_o),
		.rom_addr_o      (rom_addr_o)
	);

endmodule

// File: source/st_mem_pkg.sv
package st_mem_pkg;

	////////////////////////////////////////
	// widths
	////////////////////////////////////////

	// sdram word address, byte address bits 23:1
	localparam int addr_w = 23;
	localparam int data_w = 16;

	////////////////////////////////////////
	// memory map
	////////////////////////////////////////

	// upload start points as word addresses
	// tos 256k at e00000
	localparam logic [addr_w-1:0] base_tos256 = 23'h700000;
	// tos 192k at fc0000
	localparam logic [addr_w-1:0] base_tos192 = 23'h7e0000;
	// cartridge at fa0000
	localparam logic [addr_w-1:0] base_cart   = 23'h7d0000;

	// viking frame buffer, top six byte address bits
	// c0xxxx on a plain st
	localparam logic [5:0] viking_win_lo = 6'b110000;
	// e8xxxx in steroids mode
	localparam logic [5:0] viking_win_hi = 6'b111010;

	// enough hits in the window to trust the driver
	localparam logic [7:0] viking_count_max = 8'd255;

	// bus cycle numbering inside one 2 MHz period
	localparam logic [1:0] slot_cpu_pre = 2'd0;
	localparam logic [1:0] slot_cpu     = 2'd1;
	localparam logic [1:0] slot_video   = 2'd2;
	localparam logic [1:0] slot_extra   = 2'd3;

	////////////////////////////////////////
	// types
	////////////////////////////////////////

	typedef enum logic [2:0] {
		mem_512k = 3'd0,
		mem_1m   = 3'd1,
		mem_2m   = 3'd2,
		mem_4m   = 3'd3,
		mem_8m   = 3'd4,
		mem_14m  = 3'd5
	} mem_size_e;

	// core options, quasi static
	typedef struct packed {
		mem_size_e mem_size;
		logic      viking_en;
		logic      steroids;
		logic      turbo_bus;
	} st_cfg_t;

	// host download port
	typedef struct packed {
		logic        download;
		logic        wr;
		logic [4:0]  index;
		logic [24:0] addr;
		logic [15:0] dout;
	} ioctl_t;

	// chipset side of the ram port
	typedef struct packed {
		logic [addr_w-1:0] addr;
		logic              ras_n;
		logic              we_n;
		logic              uds;
		logic              lds;
		logic [data_w-1:0] din;
	} chip_ram_t;

	// request towards the sdram controller
	typedef struct packed {
		logic [addr_w-1:0] addr;
		logic              req;
		logic              we;
		logic              uds;
		logic              lds;
		logic [data_w-1:0] din;
	} sdram_req_t;

endpackage

// File: source/upload_addr.sv
`timescale 1ns/100ps

module upload_addr (
	input  logic                          clk_32,
	input  logic                          xsint,
	input  st_mem_pkg::ioctl_t            ioctl_i,
	output logic                          up_active_o,
	output logic [st_mem_pkg::addr_w-1:0] up_addr_o,
	output logic [st_mem_pkg::data_w-1:0] up_data_o,
	output logic                          up_toggle_o,
	output logic                          tos192k_o
);

	// first clock of a download
	logic dl_rise;
	// host strobe that belongs to a running download
	logic dl_wr;
	// index 4 sends the pointer in its first two words
	logic ptr_wr;

	assign dl_rise = ioctl_i.download & ~up_active_o;
	assign dl_wr   = ioctl_i.wr & ioctl_i.download;
	assign ptr_wr  = dl_wr && (ioctl_i.index == 5'd4) && (ioctl_i.addr[24:2] == '0);

	////////////////////////////////////////
	// address and toggle
	////////////////////////////////////////

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			up_active_o <= 1'b0;
			up_addr_o   <= '0;
			up_toggle_o <= 1'b0;
		end else begin
			up_active_o <= ioctl_i.download;
			// one below the base so the first word steps onto it
			if (dl_rise) begin
				case (ioctl_i.index)
					5'd0: up_addr_o <= st_mem_pkg::base_tos256 - 1'b1;
					5'd1: up_addr_o <= st_mem_pkg::base_tos192 - 1'b1;
					5'd2: up_addr_o <= st_mem_pkg::base_cart - 1'b1;
					// memory clear
					5'd3: up_addr_o <= '0;
					// custom pointer follows in the data
					default: up_addr_o <= up_addr_o;
				endcase
			end
			if (ptr_wr) begin
				// low word first and then the top bits
				// full pointer sits one below its value like a base
				if (ioctl_i.addr == '0)
					up_addr_o[15:0] <= ioctl_i.dout;
				else
					up_addr_o <= {ioctl_i.dout[6:0], up_addr_o[15:0]} - 1'b1;
			end else if (dl_wr) begin
				up_addr_o   <= up_addr_o + 1'b1;
				// mux sees a new word by the edge
				up_toggle_o <= ~up_toggle_o;
			end
		end
	end

	// host sends little endian and the 68000 wants big
	always_ff @(posedge clk_32) begin
		if (dl_wr && !ptr_wr)
			up_data_o <= {ioctl_i.dout[7:0], ioctl_i.dout[15:8]};
	end

	////////////////////////////////////////
	// tos size flag
	////////////////////////////////////////

	// fc0000 and up means a 192k image
	// e0xxxx means a 256k image
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			tos192k_o <= 1'b0;
		end else if (up_active_o) begin
			if (&up_addr_o[22:17])
				tos192k_o <= 1'b1;
			else if (up_addr_o[22:19] == 4'he)
				tos192k_o <= 1'b0;
		end
	end

	// address only moves on a download start or a host word
	a_addr_moves_on_event: assert property (
		@(posedge clk_32) disable iff (!xsint)
		!(dl_rise || dl_wr) |=> $stable(up_addr_o)
	);

endmodule

// File: source/viking_detect.sv
`timescale 1ns/100ps

module viking_detect (
	input  logic                          clk_32,
	input  logic                          xsint,
	input  st_mem_pkg::st_cfg_t           cfg_i,
	input  logic [st_mem_pkg::addr_w-1:0] mbus_a_i,
	input  logic                          as_n_i,
	input  logic                          mhz8_en1_i,
	output logic                          viking_enable_o,
	output logic                          viking_active_o
);

	// window hits seen so far
	logic [7:0] hits;
	// bus address falls in the frame buffer
	logic win_hit;
	logic full;

	// card memory clashes with st ram above 8M
	// steroids moves it out of the way
	assign viking_enable_o = (cfg_i.viking_en && (cfg_i.mem_size <= st_mem_pkg::mem_8m)) ||
	                         cfg_i.steroids;

	assign win_hit = (mbus_a_i[22:17] == (cfg_i.steroids ? st_mem_pkg::viking_win_hi :
	                                                       st_mem_pkg::viking_win_lo));

	assign full = (hits == st_mem_pkg::viking_count_max);

	////////////////////////////////////////
	// driver detection
	////////////////////////////////////////

	// a probing program touches the window a few times
	// a running driver keeps hammering it
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			hits            <= '0;
			viking_active_o <= 1'b0;
		end else begin
			if (!viking_enable_o)
				hits <= '0;
			else if (mhz8_en1_i && !as_n_i && win_hit && !full)
				hits <= hits + 1'b1;
			viking_active_o <= full & viking_enable_o;
		end
	end

	// card drops out at most one clock after its option goes away
	a_active_needs_enable: assert property (
		@(posedge clk_32) disable iff (!xsint)
		(viking_active_o && !viking_enable_o) |-> $changed(cfg_i)
	);

endmodule

// File: verif/tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

////////////////////////////////////////
// reference rules
////////////////////////////////////////

// host sends little endian words
function automatic logic [15:0] swap_bytes(input logic [15:0] w);
	return {w[7:0], w[15:8]};
endfunction

// st ram ends at the installed size, 14M stops short of the rom area
function automatic logic ram_ok(input logic [2:0] size, input logic [22:0] a);
	logic [23:0] byte_a;
	logic [23:0] limit;
	byte_a = {a, 1'b0};
	case (size)
		3'd0: limit = 24'h080000;
		3'd1: limit = 24'h100000;
		3'd2: limit = 24'h200000;
		3'd3: limit = 24'h400000;
		3'd4: limit = 24'h800000;
		3'd5: limit = 24'he00000;
		default: limit = 24'h000000;
	endcase
	// address 0 is a refresh cycle
	return (a != '0) && (byte_a < limit);
endfunction

// rom2 onto the tos area, 128k words
function automatic logic [22:0] rom_ref(input logic [22:0] a, input logic sel_n,
                                        input logic tos192);
	logic [23:0] area;
	area = tos192 ? 24'hfc0000 : 24'he00000;
	if (sel_n)
		return a;
	return area[23:1] + {6'd0, a[16:0]};
endfunction

task automatic note_mismatch(input logic [31:0] exp_v, input logic [31:0] act_v);
	err_count = err_count + 1;
	$display("mismatch %s expected %h actual %h", test_name, exp_v, act_v);
endtask

task automatic note_failure(input string what);
	err_count = err_count + 1;
	$display("error in %s: %s", test_name, what);
endtask

////////////////////////////////////////
// checks
////////////////////////////////////////

// upload words land at the expected address, swapped, full word write
a_up_addr: assert property (@(posedge clk_32) disable iff (!xsint)
	(up_chk && sdram.req) |-> (sdram.addr == exp_addr))
	else note_mismatch(exp_addr, $sampled(sdram.addr));

a_up_data: assert property (@(posedge clk_32) disable iff (!xsint)
	(up_chk && sdram.req) |-> (sdram.din == exp_data))
	else note_mismatch(exp_data, $sampled(sdram.din));

a_up_full: assert property (@(posedge clk_32) disable iff (!xsint)
	(up_chk && sdram.req) |-> (sdram.we && sdram.uds && sdram.lds))
	else note_failure("upload request is not a full word write");

// ras falling edge asks for sdram only inside the window
a_win_req: assert property (@(posedge clk_32) disable iff (!xsint)
	(win_chk && $fell(chip.ras_n)) |-> (sdram.req == ram_ok(cfg.mem_size, chip.addr)))
	else note_mismatch(ram_ok($sampled(cfg.mem_size), $sampled(chip.addr)),
	                   $sampled(sdram.req));

// viking card state
a_vk_idle: assert property (@(posedge clk_32) disable iff (!xsint)
	vk_idle_chk |-> !viking_active)
	else note_mismatch(0, $sampled(viking_active));

a_vk_on: assert property (@(posedge clk_32) disable iff (!xsint)
	vk_on_chk |-> viking_active)
	else note_mismatch(1, $sampled(viking_active));

// video slot fetch for the card
a_vk_fetch: assert property (@(posedge clk_32) disable iff (!xsint)
	(vk_fetch_chk && viking_read && bus_cycle == 2'd2) |-> (sdram.req && !sdram.we))
	else note_failure("no sdram read in the viking video slot");

a_vk_addr: assert property (@(posedge clk_32) disable iff (!xsint)
	(vk_fetch_chk && viking_read && bus_cycle == 2'd2) |-> (sdram.addr == viking_vaddr))
	else note_mismatch($sampled(viking_vaddr), $sampled(sdram.addr));

// tos size flag and rom remap
a_tos: assert property (@(posedge clk_32) disable iff (!xsint)
	tos_chk |-> (tos192k == exp_tos))
	else note_mismatch(exp_tos, $sampled(tos192k));

a_rom: assert property (@(posedge clk_32) disable iff (!xsint)
	rom_chk |-> (rom_addr == rom_ref(mbus_a, rom2_n, exp_tos)))
	else note_mismatch(rom_ref($sampled(mbus_a), $sampled(rom2_n), exp_tos),
	                   $sampled(rom_addr));

`endif

// File: verif/tb_st_mem_glue.sv
`timescale 1ns/100ps

module tb_st_mem_glue;

	// toggle flip to the next slot 0 strobe takes 16 clocks worst case
	localparam int req_wait_max = 40;
	// 20 upload words plus 90 ras cycles plus 510 viking accesses and a margin
	localparam int cycle_limit = 20 * 20 + 90 * 2 + 510 * 5 + 870;

	logic                          clk_32 = 1'b0;
	logic                          xsint;
	st_mem_pkg::st_cfg_t           cfg;
	st_mem_pkg::ioctl_t            ioctl;
	st_mem_pkg::chip_ram_t         chip;
	logic [st_mem_pkg::addr_w-1:0] mbus_a;
	logic                          as_n;
	logic                          rom2_n;
	logic [1:0]                    bus_cycle;
	logic                          mhz8_en1;
	logic [st_mem_pkg::addr_w-1:0] viking_vaddr;
	logic                          viking_read;
	st_mem_pkg::sdram_req_t        sdram;
	logic [st_mem_pkg::addr_w-1:0] rom_addr;
	logic                          viking_active;
	logic                          tos192k;

	// check enables
	logic        up_chk;
	logic        win_chk;
	logic        vk_idle_chk;
	logic        vk_on_chk;
	logic        vk_fetch_chk;
	logic        tos_chk;
	logic        rom_chk;
	// expected values
	logic [22:0] exp_addr;
	logic [15:0] exp_data;
	logic        exp_tos;
	logic [1:0]  phase;
	logic [31:0] rng = 32'd6;
	int          cycles = 0;
	int          err_count = 0;
	int          test_err0 = 0;
	int          test_count = 0;
	int          fail_count = 0;
	string       test_name = "reset";

	always #10 clk_32 = ~clk_32;

	// 8 MHz strobe every fourth clock
	// bus cycle steps on the strobe edge
	always @(posedge clk_32) begin
		#2;
		if (mhz8_en1)
			bus_cycle = bus_cycle + 2'd1;
		phase    = phase + 2'd1;
		mhz8_en1 = (phase == 2'd3);
	end

	always @(posedge clk_32) begin
		cycles = cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("timeout after %0d cycles, test %s did not finish", cycles, test_name);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	st_mem_glue dut_i (
		.clk_32          (clk_32),
		.xsint           (xsint),
		.cfg_i           (cfg),
		.ioctl_i         (ioctl),
		.chip_i          (chip),
		.mbus_a_i        (mbus_a),
		.as_n_i          (as_n),
		.rom2_n_i        (rom2_n),
		.bus_cycle_i     (bus_cycle),
		.mhz8_en1_i      (mhz8_en1),
		.viking_vaddr_i  (viking_vaddr),
		.viking_read_i   (viking_read),
		.sdram_o         (sdram),
		.rom_addr_o      (rom_addr),
		.viking_active_o (viking_active),
		.tos192k_o       (tos192k)
	);

	`include "tb_checks.svh"

	////////////////////////////////////////
	// stimulus helpers
	////////////////////////////////////////

	function automatic logic [31:0] next_rand();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	task automatic start_test(input string name);
		test_name = name;
		test_err0 = err_count;
	endtask

	task automatic end_test();
		test_count = test_count + 1;
		if (err_count == test_err0) begin
			$display("test %s done, no errors", test_name);
		end else begin
			fail_count = fail_count + 1;
			$display("test %s done, %0d errors", test_name, err_count - test_err0);
		end
	endtask

	// one host strobe
	task automatic send_word(input logic [15:0] w, input logic [24:0] a);
		@(posedge clk_32);
		#2;
		ioctl.wr   = 1'b1;
		ioctl.addr = a;
		ioctl.dout = w;
		@(posedge clk_32);
		#2;
		ioctl.wr = 1'b0;
	endtask

	// req sampled mid cycle when the bus cycle has settled
	task automatic wait_req(output logic seen);
		int k;
		seen = 1'b0;
		for (k = 0; k < req_wait_max && !seen; k++) begin
			@(negedge clk_32);
			if (sdram.req)
				seen = 1'b1;
		end
	endtask

	// one download with word n expected at first_addr plus n
	task automatic run_upload(input logic [4:0] idx, input logic [22:0] first_addr,
	                          input logic [22:0] ptr, input int words);
		logic [31:0] r;
		logic        seen;
		int          n;
		@(posedge clk_32);
		#2;
		ioctl.index    = idx;
		ioctl.download = 1'b1;
		repeat (2) @(posedge clk_32);
		#2;
		// index 4 opens with the pointer and the low half goes first
		if (idx == 5'd4) begin
			send_word(ptr[15:0], 25'd0);
			send_word({9'd0, ptr[22:16]}, 25'd1);
		end
		up_chk = 1'b1;
		for (n = 0; n < words; n++) begin
			r        = next_rand();
			exp_addr = first_addr + n[22:0];
			exp_data = swap_bytes(r[15:0]);
			send_word(r[15:0], 25'd4 + 25'(2 * n));
			wait_req(seen);
			if (!seen)
				note_failure("upload word never reached the sdram port");
			// request edge goes by before the next expected word
			@(posedge clk_32);
			#2;
		end
		up_chk = 1'b0;
		@(posedge clk_32);
		#2;
		ioctl.download = 1'b0;
		repeat (2) @(posedge clk_32);
	endtask

	// ras low for one clock and high for the next
	task automatic ras_cycle(input logic [22:0] a);
		@(posedge clk_32);
		#2;
		chip.addr  = a;
		chip.ras_n = 1'b0;
		@(posedge clk_32);
		#2;
		chip.ras_n = 1'b1;
	endtask

	// four clocks of as_n low hold exactly one 8 MHz strobe
	task automatic bus_access();
		logic [31:0] r;
		r = next_rand();
		@(posedge clk_32);
		#2;
		// byte address c0xxxx
		mbus_a = {8'hc0, r[14:0]};
		as_n   = 1'b0;
		repeat (4) @(posedge clk_32);
		#2;
		as_n = 1'b1;
	endtask

	task automatic check_tos(input logic want);
		@(posedge clk_32);
		#2;
		exp_tos = want;
		tos_chk = 1'b1;
		@(posedge clk_32);
		#2;
		tos_chk = 1'b0;
	endtask

	task automatic rom_check(input logic sel_n);
		logic [31:0] r;
		r = next_rand();
		@(posedge clk_32);
		#2;
		mbus_a  = r[22:0];
		rom2_n  = sel_n;
		rom_chk = 1'b1;
		@(posedge clk_32);
		#2;
		rom_chk = 1'b0;
		rom2_n  = 1'b1;
	endtask

	////////////////////////////////////////
	// test sequence
	////////////////////////////////////////

	initial begin
		logic [31:0] r;
		logic [22:0] ptr;
		logic [23:0] b256;
		logic [23:0] b192;
		logic [23:0] bcart;
		int          s;
		int          k;
		b256         = 24'he00000;
		b192         = 24'hfc0000;
		bcart        = 24'hfa0000;
		xsint        = 1'b0;
		cfg          = '0;
		cfg.mem_size = st_mem_pkg::mem_4m;
		ioctl        = '0;
		chip         = '0;
		chip.ras_n   = 1'b1;
		chip.we_n    = 1'b1;
		mbus_a       = '0;
		as_n         = 1'b1;
		rom2_n       = 1'b1;
		bus_cycle    = '0;
		mhz8_en1     = 1'b0;
		phase        = '0;
		viking_vaddr = '0;
		viking_read  = 1'b0;
		up_chk       = 1'b0;
		win_chk      = 1'b0;
		vk_idle_chk  = 1'b0;
		vk_on_chk    = 1'b0;
		vk_fetch_chk = 1'b0;
		tos_chk      = 1'b0;
		rom_chk      = 1'b0;
		exp_addr     = '0;
		exp_data     = '0;
		exp_tos      = 1'b0;
		repeat (5) @(posedge clk_32);
		#2;
		xsint = 1'b1;

		// fixed base uploads with bases as byte addresses halved
		start_test("upload");
		run_upload(5'd0, b256[23:1], '0, 4);
		run_upload(5'd1, b192[23:1], '0, 4);
		run_upload(5'd2, bcart[23:1], '0, 4);
		end_test();

		// data words start right at the pointer
		start_test("pointer");
		r   = next_rand();
		ptr = r[22:0];
		run_upload(5'd4, ptr, ptr, 4);
		end_test();

		start_test("ram window");
		win_chk = 1'b1;
		for (s = 0; s < 6; s++) begin
			@(posedge clk_32);
			#2;
			cfg.mem_size = st_mem_pkg::mem_size_e'(s);
			ras_cycle('0);
			ras_cycle(23'h700000);
			ras_cycle(23'h7fffff);
			// shifted randoms land on both sides of every limit
			for (k = 0; k < 12; k++) begin
				r = next_rand();
				ras_cycle(r[22:0] >> r[26:24]);
			end
		end
		win_chk = 1'b0;
		end_test();

		start_test("viking");
		@(posedge clk_32);
		#2;
		cfg = '{mem_size: st_mem_pkg::mem_2m, viking_en: 1'b1, steroids: 1'b0,
		        turbo_bus: 1'b0};
		vk_idle_chk = 1'b1;
		for (k = 0; k < 254; k++)
			bus_access();
		repeat (2) @(posedge clk_32);
		#2;
		vk_idle_chk = 1'b0;
		bus_access();
		repeat (2) @(posedge clk_32);
		#2;
		vk_on_chk = 1'b1;
		@(posedge clk_32);
		#2;
		vk_on_chk = 1'b0;
		// frame buffer fetch in the video slot
		r            = next_rand();
		viking_vaddr = r[22:0];
		viking_read  = 1'b1;
		vk_fetch_chk = 1'b1;
		repeat (20) @(posedge clk_32);
		#2;
		vk_fetch_chk = 1'b0;
		viking_read  = 1'b0;
		// 14M leaves no room for the card
		cfg.mem_size = st_mem_pkg::mem_14m;
		repeat (2) @(posedge clk_32);
		#2;
		vk_idle_chk = 1'b1;
		for (k = 0; k < 255; k++)
			bus_access();
		repeat (2) @(posedge clk_32);
		#2;
		vk_idle_chk = 1'b0;
		end_test();

		start_test("rom remap");
		cfg          = '0;
		cfg.mem_size = st_mem_pkg::mem_4m;
		run_upload(5'd1, b192[23:1], '0, 2);
		check_tos(1'b1);
		for (k = 0; k < 6; k++)
			rom_check(1'b0);
		run_upload(5'd0, b256[23:1], '0, 2);
		check_tos(1'b0);
		for (k = 0; k < 6; k++)
			rom_check(1'b0);
		// rom2 deselected passes straight through
		for (k = 0; k < 6; k++)
			rom_check(1'b1);
		end_test();

		$display("%0d tests, %0d failed, %0d errors", test_count, fail_count, err_count);
		if (err_count == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule
